// ==== Makefile ====
# Verilator build and run of the 64b/66b scrambling path testbench
# the simulator exits non-zero when the testbench stops with $fatal

VERILATOR ?= verilator
TOP       ?= tb_pcs_scramble
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
+incdir+verilog
+incdir+sim
verilog/pcs_pkg.sv
verilog/pcs_tx_ctrl.sv
verilog/block_encoder.sv
verilog/scrambler_64.sv
verilog/descrambler_64.sv
verilog/pcs_scramble_top.sv
sim/tb_pcs_scramble.sv

// ==== sim/tb_pcs_model.svh ====
// reference model for block encoding and the 1 + x^39 + x^58 scrambler pair
// included inside the testbench module, which imports pcs_pkg
`ifndef TB_PCS_MODEL_SVH
`define TB_PCS_MODEL_SVH

`include "pcs_cfg.svh"

localparam int BLK_W  = `PCS_SYNC_W + `PCS_DATA_W;
localparam int HIST_W = `PCS_SCR_TAP_B;
localparam int LINE_W = HIST_W + `PCS_DATA_W;

// stream history, oldest bit at index 0, newest at HIST_W-1
logic [HIST_W-1:0] mdl_scr_hist;
logic [HIST_W-1:0] mdl_dsc_hist;

function automatic void model_reset();
    mdl_scr_hist = `PCS_SCR_SEED;
    mdl_dsc_hist = `PCS_SCR_SEED;
endfunction

// ------------------------------------------------------------
// 64b/66b block from one xgmii word, as {sync, payload}
// ------------------------------------------------------------
function automatic logic [BLK_W-1:0] encode_word(input pcs_data_t data,
                                                 input pcs_ctl_t  ctl);
    logic      idle;
    pcs_data_t payload;
    idle = (ctl == '1);
    for (int b = 0; b < `PCS_CTL_W; b++) begin
        if (data[8*b +: 8] != `PCS_IDLE_CHAR) begin
            idle = 1'b0;
        end
    end
    if (ctl == '0) begin
        return {`PCS_SYNC_DATA, data};
    end
    payload      = '0;
    payload[7:0] = `PCS_TYPE_CTRL;
    // error block, one 7-bit code per lane above the type byte
    if (!idle) begin
        for (int k = 0; k < `PCS_CTL_W; k++) begin
            payload[8 + 7*k +: 7] = `PCS_CODE_ERR;
        end
    end
    return {`PCS_SYNC_CTRL, payload};
endfunction

// ------------------------------------------------------------
// bit serial scrambler, line holds history then the new bits
// ------------------------------------------------------------
function automatic pcs_data_t scramble_payload(input pcs_data_t din);
    logic [LINE_W-1:0] line;
    pcs_data_t         dout;
    line = {{`PCS_DATA_W{1'b0}}, mdl_scr_hist};
    for (int i = 0; i < `PCS_DATA_W; i++) begin
        // taps sit 39 and 58 bits back in the scrambled stream
        dout[i] = din[i]
                ^ line[HIST_W + i - `PCS_SCR_TAP_A]
                ^ line[HIST_W + i - `PCS_SCR_TAP_B];
        line[HIST_W + i] = dout[i];
    end
    mdl_scr_hist = line[LINE_W-1 -: HIST_W];
    return dout;
endfunction

// same taps, history from the received stream
function automatic pcs_data_t descramble_payload(input pcs_data_t din);
    logic [LINE_W-1:0] line;
    pcs_data_t         dout;
    line = {{`PCS_DATA_W{1'b0}}, mdl_dsc_hist};
    for (int i = 0; i < `PCS_DATA_W; i++) begin
        dout[i] = din[i]
                ^ line[HIST_W + i - `PCS_SCR_TAP_A]
                ^ line[HIST_W + i - `PCS_SCR_TAP_B];
        line[HIST_W + i] = din[i];
    end
    mdl_dsc_hist = line[LINE_W-1 -: HIST_W];
    return dout;
endfunction

`endif

// ==== sim/tb_pcs_scramble.sv ====
// random words through encoder and scrambler, output looped into the descrambler
// fixed seed; latency checked only while out_ready is held high
`timescale 1ns/1ns
`default_nettype none

`include "pcs_cfg.svh"

module tb_pcs_scramble
    import pcs_pkg::*;
();

    localparam int N_DATA   = 300;
    localparam int N_CTRL   = 200;
    localparam int N_RAND   = 400;
    localparam int N_RST    = 150;
    localparam int N_TOTAL  = N_DATA + N_CTRL + N_RAND + N_RST;
    localparam int CLK_HALF = 50;

    logic      clk = 1'b0;
    logic      rst;
    logic      tx_valid;
    pcs_data_t tx_data;
    pcs_ctl_t  tx_ctl;
    logic      tx_ready;
    logic      out_ready;
    logic      out_valid;
    pcs_sync_t out_sync;
    pcs_data_t out_payload;
    logic      rx_valid;
    pcs_sync_t rx_sync;
    pcs_data_t rx_payload;
    logic      dsc_valid;
    pcs_sync_t dsc_sync;
    pcs_data_t dsc_payload;

    `include "tb_pcs_model.svh"

    // expected scrambled, encoded and descrambled blocks, accept cycles
    logic [BLK_W-1:0] exp_out_q[$];
    logic [BLK_W-1:0] exp_enc_q[$];
    logic [BLK_W-1:0] exp_dsc_q[$];
    int               exp_cyc_q[$];

    int               cyc = 0;
    logic             ready_random = 1'b0;
    logic             lat_check = 1'b0;
    logic             prev_rx_valid = 1'b0;
    logic             hold_pending = 1'b0;
    logic [BLK_W-1:0] hold_blk;
    int unsigned      seed_val;

    pcs_scramble_top i_dut (.*);

    always #CLK_HALF clk = ~clk;

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR: %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // scoreboard and rx loopback
    // ------------------------------------------------------------
    always @(posedge clk) begin : scoreboard
        logic [BLK_W-1:0] exp_blk;
        logic [BLK_W-1:0] enc_blk;
        int               acc_cyc;
        cyc = cyc + 1;
        if (rst) begin
            // blocks in flight are dropped by the reset
            exp_out_q.delete();
            exp_enc_q.delete();
            exp_dsc_q.delete();
            exp_cyc_q.delete();
            model_reset();
            prev_rx_valid = 1'b0;
            hold_pending  = 1'b0;
            rx_valid     <= 1'b0;
        end else begin
            // descrambler answers one cycle after rx_valid
            check_equal(dsc_valid, prev_rx_valid, "dsc_valid timing");
            if (dsc_valid) begin
                exp_blk = exp_dsc_q.pop_front();
                check_equal({dsc_sync, dsc_payload}, exp_blk, "descrambled block");
            end
            prev_rx_valid = rx_valid;
            // stalled block must hold
            if (hold_pending) begin
                check_equal(out_valid, 1'b1, "out_valid dropped during stall");
                check_equal({out_sync, out_payload}, hold_blk, "output moved during stall");
            end
            hold_pending = out_valid && !out_ready;
            hold_blk     = {out_sync, out_payload};
            rx_valid   <= out_valid && out_ready;
            rx_sync    <= out_sync;
            rx_payload <= out_payload;
            if (out_valid && out_ready) begin
                if (exp_out_q.size() == 0) begin
                    $display("Some tests failed");
                    $fatal(1, "a block left the transmit path that was never accepted");
                end
                exp_blk = exp_out_q.pop_front();
                enc_blk = exp_enc_q.pop_front();
                acc_cyc = exp_cyc_q.pop_front();
                check_equal({out_sync, out_payload}, exp_blk, "scrambled block");
                if (acc_cyc >= 0) begin
                    check_equal(cyc, acc_cyc + 2, "accept to output latency");
                end
                exp_dsc_q.push_back(enc_blk);
            end
            if (tx_valid && tx_ready) begin
                enc_blk = encode_word(tx_data, tx_ctl);
                exp_enc_q.push_back(enc_blk);
                exp_out_q.push_back({enc_blk[BLK_W-1 -: `PCS_SYNC_W],
                                     scramble_payload(enc_blk[`PCS_DATA_W-1:0])});
                exp_cyc_q.push_back(lat_check ? cyc : -1);
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    task automatic tick();
        out_ready <= ready_random ? ($urandom % 3 != 0) : 1'b1;
        @(posedge clk);
    endtask

    // data held until tx_ready, then an occasional idle cycle
    task automatic send_word(input pcs_data_t data, input pcs_ctl_t ctl);
        tx_valid <= 1'b1;
        tx_data  <= data;
        tx_ctl   <= ctl;
        tick();
        while (!tx_ready) begin
            tick();
        end
        tx_valid <= 1'b0;
        if ($urandom % 4 == 0) begin
            tick();
        end
    endtask

    // kind 0 data, 1 idle, 2 random flags, 3 idle chars with some flags, 4 all flags
    task automatic send_random(input int unsigned kind);
        pcs_data_t data;
        pcs_ctl_t  ctl;
        data = {$urandom, $urandom};
        ctl  = '0;
        case (kind)
            1: begin
                data = {`PCS_CTL_W{`PCS_IDLE_CHAR}};
                ctl  = '1;
            end
            2: ctl = pcs_ctl_t'($urandom);
            3: begin
                data = {`PCS_CTL_W{`PCS_IDLE_CHAR}};
                ctl  = pcs_ctl_t'($urandom) | pcs_ctl_t'(1);
            end
            4: ctl = '1;
            default: ;
        endcase
        send_word(data, ctl);
    endtask

    // run until pipeline, loopback and descrambler are empty
    task automatic drain();
        ready_random = 1'b0;
        tx_valid <= 1'b0;
        tick();
        while (i_dut.i_tx_ctrl.state != EMPTY || rx_valid || dsc_valid) begin
            tick();
        end
        repeat (2) tick();
    endtask

    task automatic apply_reset();
        rst      <= 1'b1;
        tx_valid <= 1'b0;
        repeat (4) tick();
        rst <= 1'b0;
        tick();
        check_equal(out_valid, 1'b0, "out_valid after reset");
        check_equal(dsc_valid, 1'b0, "dsc_valid after reset");
        check_equal(tx_ready, 1'b1, "tx_ready after reset");
        check_equal(i_dut.i_scrambler.scr_state, `PCS_SCR_SEED, "scrambler seed");
        check_equal(i_dut.i_descrambler.dsc_state, `PCS_SCR_SEED, "descrambler seed");
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        seed_val   = $urandom(32'h347115fe);
        rst        = 1'b1;
        tx_valid   = 1'b0;
        tx_data    = '0;
        tx_ctl     = '0;
        out_ready  = 1'b1;
        rx_valid   = 1'b0;
        rx_sync    = '0;
        rx_payload = '0;
        model_reset();
        apply_reset();
        // data blocks, then idle and error blocks, no back-pressure
        lat_check = 1'b1;
        repeat (N_DATA) send_random(0);
        drain();
        repeat (N_CTRL) send_random($urandom % 5);
        drain();
        // random back-pressure and gaps
        lat_check    = 1'b0;
        ready_random = 1'b1;
        repeat (N_RAND) send_random($urandom % 5);
        drain();
        // reset with blocks in flight, then carry on
        ready_random = 1'b1;
        repeat (N_RST / 5) send_random($urandom % 5);
        apply_reset();
        repeat (N_RST - N_RST / 5) send_random($urandom % 5);
        drain();
        if (exp_out_q.size() != 0 || exp_dsc_q.size() != 0) begin
            $display("Some tests failed");
            $fatal(1, "blocks still expected at the end: %0d transmit, %0d receive",
                   exp_out_q.size(), exp_dsc_q.size());
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    // about 20 cycles per word
    initial begin : watchdog
        #(N_TOTAL * 20 * 2 * CLK_HALF);
        $display("Some tests failed");
        $fatal(1, "timeout, the run did not finish within %0d cycles", N_TOTAL * 20);
    end

endmodule

`default_nettype wire

// ==== verilog/block_encoder.sv ====
// data, idle and error blocks only; start, terminate and ordered sets
// fall into the error block
`timescale 1ns/1ns
`default_nettype none

`include "pcs_cfg.svh"

module block_encoder
    import pcs_pkg::*;
(
    input  var logic      clk,
    input  var logic      rst,
    input  var logic      stage_en_enc,
    input  var pcs_data_t tx_data,
    input  var pcs_ctl_t  tx_ctl,
    output var pcs_sync_t enc_sync,
    output var pcs_data_t enc_payload
);

    localparam int BYTE_W = `PCS_DATA_W / `PCS_CTL_W;

    logic       is_data;
    logic       all_ctl;
    logic       all_idle_chars;
    pcs_sync_t  sync_c;
    pcs_data_t  payload_c;

    // ------------------------------------------------------------
    // classify the xgmii word
    // ------------------------------------------------------------
    assign is_data = (tx_ctl == '0);
    assign all_ctl = &tx_ctl;

    // every lane carries the idle character
    always_comb begin
        all_idle_chars = 1'b1;
        for (int b = 0; b < `PCS_CTL_W; b++) begin
            if (tx_data[b*BYTE_W +: BYTE_W] != `PCS_IDLE_CHAR) begin
                all_idle_chars = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // build sync header and payload
    // ------------------------------------------------------------
    always_comb begin
        if (is_data) begin
            sync_c    = `PCS_SYNC_DATA;
            payload_c = tx_data;
        end else if (all_ctl && all_idle_chars) begin
            // type byte low, eight idle codes of zero above
            sync_c    = `PCS_SYNC_CTRL;
            payload_c = {{(`PCS_DATA_W-8){1'b0}}, `PCS_TYPE_CTRL};
        end else begin
            // anything else becomes eight error codes
            sync_c    = `PCS_SYNC_CTRL;
            payload_c = {{`PCS_CTL_W{`PCS_CODE_ERR}}, `PCS_TYPE_CTRL};
        end
    end

    // ------------------------------------------------------------
    // stage 1 register
    // ------------------------------------------------------------
    // header cleared to the invalid 2'b00 until the first block
    always_ff @(posedge clk) begin
        if (rst) begin
            enc_sync <= '0;
        end else if (stage_en_enc) begin
            enc_sync <= sync_c;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_en_enc) begin
            enc_payload <= payload_c;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/descrambler_64.sv ====
// self-synchronous descrambler for 1 + x^39 + x^58, no back-pressure
// a wrong seed flushes out after 58 received bits
`timescale 1ns/1ns
`default_nettype none

`include "pcs_cfg.svh"

module descrambler_64
    import pcs_pkg::*;
(
    input  var logic      clk,
    input  var logic      rst,
    input  var logic      rx_valid,
    input  var pcs_sync_t rx_sync,
    input  var pcs_data_t rx_payload,
    output var logic      dsc_valid,
    output var pcs_sync_t dsc_sync,
    output var pcs_data_t dsc_payload
);

    pcs_scr_state_t dsc_state;
    pcs_scr_state_t dsc_state_next;
    pcs_data_t      plain_payload;

    // same taps as the scrambler, history from received bits
    always_comb begin
        pcs_scr_state_t hist;
        hist = dsc_state;
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            plain_payload[i] = rx_payload[i]
                             ^ hist[`PCS_SCR_TAP_A-1]
                             ^ hist[`PCS_SCR_TAP_B-1];
            hist = {hist[`PCS_SCR_TAP_B-2:0], rx_payload[i]};
        end
        dsc_state_next = hist;
    end

    // ------------------------------------------------------------
    // output register, one cycle after rx_valid
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dsc_valid <= 1'b0;
            dsc_state <= `PCS_SCR_SEED;
        end else begin
            dsc_valid <= rx_valid;
            if (rx_valid) begin
                dsc_state <= dsc_state_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            dsc_sync    <= rx_sync;
            dsc_payload <= plain_payload;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pcs_cfg.svh ====
// widths, scrambler taps and 64b/66b code constants shared by package and RTL
// single lane only; tap B also sets the scrambler history length
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// block geometry
`define PCS_DATA_W      64
`define PCS_SYNC_W      2
`define PCS_CTL_W       8

// scrambler polynomial 1 + x^39 + x^58
`define PCS_SCR_TAP_A   39
`define PCS_SCR_TAP_B   58
`define PCS_SCR_SEED    58'h3FF_FFFF_FFFF_FFFF

// sync headers and control codes
`define PCS_SYNC_DATA   2'b01
`define PCS_SYNC_CTRL   2'b10
`define PCS_IDLE_CHAR   8'h07
`define PCS_TYPE_CTRL   8'h1E
`define PCS_CODE_ERR    7'h1E

`endif

// ==== verilog/pcs_pkg.sv ====
// types for the 64b/66b scrambling path; widths come from the cfg header
`default_nettype none

`include "pcs_cfg.svh"

package pcs_pkg;

    // 64-bit payload or xgmii data word
    typedef logic [`PCS_DATA_W-1:0] pcs_data_t;

    // 2-bit sync header, bypasses the scrambler
    typedef logic [`PCS_SYNC_W-1:0] pcs_sync_t;

    // one control flag per data byte
    typedef logic [`PCS_CTL_W-1:0] pcs_ctl_t;

    // block type byte of a control block
    typedef logic [7:0] pcs_btype_t;

    // scrambler history, newest bit at index 0
    typedef logic [`PCS_SCR_TAP_B-1:0] pcs_scr_state_t;

    // blocks held in the two transmit stages
    typedef enum logic [1:0] {
        EMPTY,
        HALF,
        FULL
    } pipe_state_e;

endpackage

`default_nettype wire

// ==== verilog/pcs_scramble_top.sv ====
// one-lane 64b/66b encode and scramble path with a separate descrambler
// tx latency 2 cycles plus stalls, rx latency 1 cycle
`timescale 1ns/1ns
`default_nettype none

`include "pcs_cfg.svh"

module pcs_scramble_top
    import pcs_pkg::*;
(
    input  var logic      clk,
    input  var logic      rst,

    // xgmii-like input, valid/ready
    input  var logic      tx_valid,
    input  var pcs_data_t tx_data,
    input  var pcs_ctl_t  tx_ctl,
    output var logic      tx_ready,

    // scrambled 66-bit blocks, valid/ready
    input  var logic      out_ready,
    output var logic      out_valid,
    output var pcs_sync_t out_sync,
    output var pcs_data_t out_payload,

    // receive blocks, valid only
    input  var logic      rx_valid,
    input  var pcs_sync_t rx_sync,
    input  var pcs_data_t rx_payload,
    output var logic      dsc_valid,
    output var pcs_sync_t dsc_sync,
    output var pcs_data_t dsc_payload
);

    logic      stage_en_enc;
    logic      stage_en_scr;
    pcs_sync_t enc_sync;
    pcs_data_t enc_payload;

    // ------------------------------------------------------------
    // transmit path
    // ------------------------------------------------------------
    // handshakes decided here only
    pcs_tx_ctrl i_tx_ctrl (
        .clk          (clk),
        .rst          (rst),
        .tx_valid     (tx_valid),
        .out_ready    (out_ready),
        .tx_ready     (tx_ready),
        .stage_en_enc (stage_en_enc),
        .stage_en_scr (stage_en_scr),
        .out_valid    (out_valid)
    );

    // stage 1
    block_encoder i_encoder (
        .clk          (clk),
        .rst          (rst),
        .stage_en_enc (stage_en_enc),
        .tx_data      (tx_data),
        .tx_ctl       (tx_ctl),
        .enc_sync     (enc_sync),
        .enc_payload  (enc_payload)
    );

    // stage 2, drives the output block
    scrambler_64 i_scrambler (
        .clk          (clk),
        .rst          (rst),
        .stage_en_scr (stage_en_scr),
        .enc_sync     (enc_sync),
        .enc_payload  (enc_payload),
        .out_sync     (out_sync),
        .out_payload  (out_payload)
    );

    // ------------------------------------------------------------
    // receive path
    // ------------------------------------------------------------
    descrambler_64 i_descrambler (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .rx_sync      (rx_sync),
        .rx_payload   (rx_payload),
        .dsc_valid    (dsc_valid),
        .dsc_sync     (dsc_sync),
        .dsc_payload  (dsc_payload)
    );

endmodule

`default_nettype wire

// ==== verilog/pcs_tx_ctrl.sv ====
// valid/ready control for the encoder and scrambler stages
// out_ready reaches tx_ready combinationally
`timescale 1ns/1ns
`default_nettype none

`include "pcs_cfg.svh"

module pcs_tx_ctrl
    import pcs_pkg::*;
(
    input  var logic clk,
    input  var logic rst,
    input  var logic tx_valid,
    input  var logic out_ready,
    output var logic tx_ready,
    output var logic stage_en_enc,
    output var logic stage_en_scr,
    output var logic out_valid
);

    pipe_state_e state;
    pipe_state_e state_next;
    // in HALF, tells which stage holds the lone block
    logic blk_in_s2;
    logic s1_full;
    logic s2_full;
    logic s1_next;
    logic s2_next;
    logic s2_free;

    // ------------------------------------------------------------
    // stage occupancy decoded from state
    // ------------------------------------------------------------
    assign s1_full = (state == FULL) || ((state == HALF) && !blk_in_s2);
    assign s2_full = (state == FULL) || ((state == HALF) && blk_in_s2);

    // stage 2 is empty or handing its block out this cycle
    assign s2_free = !s2_full || out_ready;

    // stage 1 moves on whenever stage 2 can take it
    assign stage_en_scr = s1_full && s2_free;

    // room in stage 1 if empty or draining
    assign tx_ready     = !s1_full || stage_en_scr;
    assign stage_en_enc = tx_valid && tx_ready;

    assign out_valid = s2_full;

    // occupancy after this edge
    assign s1_next = stage_en_enc || (s1_full && !stage_en_scr);
    assign s2_next = stage_en_scr || (s2_full && !out_ready);

    always_comb begin
        unique case ({s1_next, s2_next})
            2'b00:   state_next = EMPTY;
            2'b11:   state_next = FULL;
            default: state_next = HALF;
        endcase
    end

    // ------------------------------------------------------------
    // state registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= EMPTY;
            blk_in_s2 <= 1'b0;
        end else begin
            state     <= state_next;
            // only meaningful in HALF
            blk_in_s2 <= s2_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/scrambler_64.sv ====
// self-synchronous 1 + x^39 + x^58 scrambler, 64 bits per cycle
// history advances only on stage_en_scr; sync header is not scrambled
`timescale 1ns/1ns
`default_nettype none

`include "pcs_cfg.svh"

module scrambler_64
    import pcs_pkg::*;
(
    input  var logic      clk,
    input  var logic      rst,
    input  var logic      stage_en_scr,
    input  var pcs_sync_t enc_sync,
    input  var pcs_data_t enc_payload,
    output var pcs_sync_t out_sync,
    output var pcs_data_t out_payload
);

    pcs_scr_state_t scr_state;
    pcs_scr_state_t scr_state_next;
    pcs_data_t      scr_payload;

    // ------------------------------------------------------------
    // unrolled scrambler, bit 0 goes first
    // ------------------------------------------------------------
    always_comb begin
        pcs_scr_state_t hist;
        hist = scr_state;
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            scr_payload[i] = enc_payload[i]
                           ^ hist[`PCS_SCR_TAP_A-1]
                           ^ hist[`PCS_SCR_TAP_B-1];
            // history is built from scrambled bits
            hist = {hist[`PCS_SCR_TAP_B-2:0], scr_payload[i]};
        end
        scr_state_next = hist;
    end

    // ------------------------------------------------------------
    // stage 2 registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            scr_state <= `PCS_SCR_SEED;
            out_sync  <= '0;
        end else if (stage_en_scr) begin
            scr_state <= scr_state_next;
            // header rides along, one stage behind the encoder
            out_sync  <= enc_sync;
        end
    end

    // payload holds under back-pressure
    always_ff @(posedge clk) begin
        if (stage_en_scr) begin
            out_payload <= scr_payload;
        end
    end

endmodule

`default_nettype wire
